//--- logic/qsound_params.svh
//########################################
// shared constants of the sound board glue
// include after `default_nettype in each RTL file
//########################################
`ifndef QSOUND_PARAMS_SVH
`define QSOUND_PARAMS_SVH

// DSP output words are scaled up by this shift
`define QSND_GAIN 2

// banked window starts above the fixed 32 kB of program ROM
`define ROM_BANK_BASE 19'h08000

// cen8 ticks between Z80 interrupts, 8 MHz / 32000 = 250 Hz
`define IRQ_PERIOD 32000

// register offsets inside the 0xDxxx page
`define MBOX_OFS_DHI  3'd0     // data word MSB
`define MBOX_OFS_DLO  3'd1     // data word LSB
`define MBOX_OFS_ADDR 3'd2     // register address, kicks the DSP
`define BANK_OFS      3'd3
`define STATUS_OFS    3'd7

`endif

//--- logic/z80_bus_pkg.sv
//########################################
// types seen on the Z80 side of the glue
// import into decode, mailbox and top
//########################################
`default_nettype none

package z80_bus_pkg;

    // CPU address bus
    typedef logic [15:0] z80_addr_t;

    // data byte, both directions
    typedef logic [7:0] z80_byte_t;

    // byte address into the 512 kB program ROM
    typedef logic [18:0] rom_addr_t;

    // 16 kB bank selector
    typedef logic [3:0] bank_t;

    typedef logic [1:0] mbox_idx_t;     // which command byte

endpackage

`default_nettype wire

//--- logic/dsp_link_pkg.sv
//########################################
// types seen on the DSP16 side of the glue
//########################################
`default_nettype none

package dsp_link_pkg;

    // parallel bus and serial output word
    typedef logic [15:0] dsp_word_t;

    typedef logic signed [15:0] sample_t;   // one audio channel

    // up to 8 MB of sample ROM
    typedef logic [22:0] qsnd_addr_t;

    // register address in 23:16, data in 15:0
    typedef logic [23:0] mbox_word_t;

endpackage

`default_nettype wire

//--- logic/sound_addr_decode.sv
//########################################
// Z80 memory map of the sound board
// registers chip selects one clock after the address
//########################################
`default_nettype none

`include "qsound_params.svh"

module sound_addr_decode
    import z80_bus_pkg::*;
(
    input  wire       clk48,
    input  wire       rst,
    input  z80_addr_t z80_addr,
    input  z80_byte_t z80_dout,
    input  wire       mreq_n,
    input  wire       rd_n,
    input  wire       wr_n,
    input  z80_byte_t rom_data,
    input  z80_byte_t ram_dout,
    input  bank_t     bank,
    input  wire       dsp_rdy_n,
    output rom_addr_t rom_addr,
    output logic      rom_cs,
    output logic      ram_cs,
    output logic      mbox_wr,
    output mbox_idx_t mbox_idx,
    output logic      bank_wr,
    output z80_byte_t wr_data,
    output z80_byte_t z80_din
);

    logic       status_rd;
    logic [2:0] ofs;
    logic       io_page, mem_wr, mem_rd;

    assign ofs     = z80_addr[2:0];
    assign io_page = z80_addr[15:12] == 4'hd;   // mailbox, bank and status
    assign mem_wr  = !mreq_n && !wr_n;
    assign mem_rd  = !mreq_n && !rd_n;

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            mbox_wr   <= 1'b0;
            bank_wr   <= 1'b0;
            status_rd <= 1'b0;
            rom_addr  <= '0;
        end else begin
            rom_cs    <= !mreq_n && z80_addr[15:14] != 2'b11;
            ram_cs    <= !mreq_n && (z80_addr[15:12] == 4'hc || z80_addr[15:12] == 4'hf);
            mbox_wr   <= mem_wr && io_page && ofs <= `MBOX_OFS_ADDR;
            bank_wr   <= mem_wr && io_page && ofs == `BANK_OFS;
            status_rd <= mem_rd && io_page && ofs == `STATUS_OFS;
            if (!mreq_n) begin
                // upper half maps through the bank register
                rom_addr <= z80_addr[15] ? {1'b0, bank, z80_addr[13:0]} + `ROM_BANK_BASE
                                         : {4'd0, z80_addr[14:0]};
            end
        end
    end

    // write byte and index travel alongside the strobes
    always_ff @(posedge clk48) begin
        mbox_idx <= mbox_idx_t'(ofs);
        wr_data  <= z80_dout;
    end

    always_comb begin
        if (rom_cs)
            z80_din = rom_data;
        else if (ram_cs)
            z80_din = ram_dout;
        else if (status_rd)
            z80_din = {dsp_rdy_n, 3'b111, bank};
        else
            z80_din = 8'hff;    // open bus
    end

endmodule

`default_nettype wire

//--- logic/sound_mailbox.sv
//########################################
// Z80 to DSP16 command mailbox
// also holds the ROM bank and the DSP reset bit
//########################################
`default_nettype none

`include "qsound_params.svh"

module sound_mailbox
    import z80_bus_pkg::*, dsp_link_pkg::*;
(
    input  wire       clk48,
    input  wire       rst,
    input  wire       mbox_wr,
    input  mbox_idx_t mbox_idx,
    input  wire       bank_wr,
    input  z80_byte_t wr_data,
    input  wire       dsp_pids_n,
    input  wire       dsp_iack,
    output bank_t     bank,
    output logic      dsp_rst,
    output logic      dsp_irq,
    output logic      dsp_rdy_n,
    output dsp_word_t dsp_pbus_in
);

    mbox_word_t cmd;
    logic [1:0] datasel;    // bit 1 set while the address byte is due
    logic       last_pids_n;
    logic       pids_rise;
    logic       addr_wr;

    assign pids_rise = dsp_pids_n && !last_pids_n;   // end of a DSP read
    assign addr_wr   = mbox_wr && mbox_idx == mbox_idx_t'(`MBOX_OFS_ADDR);

    // Z80 side registers
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            bank    <= '0;
            dsp_rst <= 1'b1;    // DSP held until the Z80 releases it
            cmd     <= '0;
        end else begin
            if (bank_wr) begin
                bank    <= wr_data[3:0];
                dsp_rst <= ~wr_data[7];
            end
            if (mbox_wr) begin
                case (mbox_idx)
                    mbox_idx_t'(`MBOX_OFS_DHI): cmd[15:8]  <= wr_data;
                    mbox_idx_t'(`MBOX_OFS_DLO): cmd[7:0]   <= wr_data;
                    default:                    cmd[23:16] <= wr_data;
                endcase
            end
        end
    end

    // interrupt and read sequencing towards the DSP
    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            dsp_irq     <= 1'b0;
            datasel     <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp_pids_n;
            if (addr_wr) begin
                dsp_irq <= 1'b1;
                datasel <= 2'b11;
            end else if (pids_rise) begin
                dsp_irq <= 1'b0;
                datasel <= datasel >> 1;
            end
        end
    end

    assign dsp_rdy_n   = ~(dsp_irq | dsp_iack);
    assign dsp_pbus_in = datasel[1] ? {8'd0, cmd[23:16]} : cmd[15:0];

endmodule

`default_nettype wire

//--- logic/sound_sample_latch.sv
//########################################
// captures DSP16 output words as stereo samples
// and assembles the sample ROM address
//########################################
`default_nettype none

`include "qsound_params.svh"

module sound_sample_latch
    import dsp_link_pkg::*;
(
    input  wire        clk48,
    input  wire        rst,
    input  wire        dsp_sadd,
    input  wire        dsp_psel,
    input  dsp_word_t  dsp_serout,
    input  wire        dsp_pods_n,
    input  dsp_word_t  dsp_pbus_out,
    input  dsp_word_t  dsp_ab,
    input  wire        dsp_cen_cko,
    output sample_t    left,
    output sample_t    right,
    output logic       sample,
    output qsnd_addr_t qsnd_addr
);

    sample_t reg_left, reg_right, cap_word;
    logic    last_sadd, last_psel, last_pods_n;

    // serial port bypassed, word taken in parallel
    assign cap_word = sample_t'(dsp_serout << `QSND_GAIN);

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            last_sadd   <= 1'b0;
            last_psel   <= 1'b1;
            last_pods_n <= 1'b1;
            reg_left    <= '0;
            reg_right   <= '0;
            left        <= '0;
            right       <= '0;
            sample      <= 1'b0;
            qsnd_addr   <= '0;
        end else begin
            last_sadd   <= dsp_sadd;
            last_psel   <= dsp_psel;
            last_pods_n <= dsp_pods_n;
            if (!dsp_sadd && last_sadd) begin
                if (!dsp_psel)
                    reg_left  <= cap_word;
                else
                    reg_right <= cap_word;
            end
            sample <= dsp_psel && !last_psel;   // one clock per stereo pair
            if (dsp_psel && !last_psel) begin
                left  <= reg_left;
                right <= reg_right;
            end
            if (dsp_pods_n && !last_pods_n)
                qsnd_addr[15:0] <= dsp_pbus_out;
            if (dsp_ab[15] && dsp_cen_cko)
                qsnd_addr[22:16] <= dsp_ab[6:0];    // high bits from the address bus
        end
    end

endmodule

`default_nettype wire

//--- logic/z80_tick_irq.sv
//########################################
// periodic Z80 interrupt paced by cen8
// held low until the CPU acknowledges
//########################################
`default_nettype none

`include "qsound_params.svh"

module z80_tick_irq #(
    parameter int irq_period = `IRQ_PERIOD
) (
    input  wire  clk48,
    input  wire  rst,
    input  wire  cen8,
    input  wire  m1_n,
    input  wire  iorq_n,
    output logic int_n
);

    localparam int CW = $clog2(irq_period + 1);

    logic [CW-1:0] cnt;
    logic          wrap;

    assign wrap = cnt == CW'(irq_period - 1);

    always_ff @(posedge clk48, posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;      // acknowledge cycle
            else if (wrap)
                int_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/qsound_glue.sv
//########################################
// sound board glue between Z80 and DSP16
// Z80, DSP16, work RAM and ROMs sit outside
//########################################
`default_nettype none

`include "qsound_params.svh"

module qsound_glue
    import z80_bus_pkg::*, dsp_link_pkg::*;
#(
    parameter int irq_period = `IRQ_PERIOD
) (
    input  wire             clk48,
    input  wire             rst,
    input  wire             cen8,
    // Z80
    input  z80_addr_t       z80_addr,
    input  z80_byte_t       z80_dout,
    input  wire             mreq_n,
    input  wire             rd_n,
    input  wire             wr_n,
    input  wire             m1_n,
    input  wire             iorq_n,
    output wire z80_byte_t  z80_din,
    output wire             int_n,
    // program ROM and work RAM
    output wire rom_addr_t  rom_addr,
    output wire             rom_cs,
    output wire             ram_cs,
    input  z80_byte_t       rom_data,
    input  z80_byte_t       ram_dout,
    // DSP16
    input  wire             dsp_pids_n,
    input  wire             dsp_iack,
    input  wire             dsp_sadd,
    input  wire             dsp_psel,
    input  dsp_word_t       dsp_serout,
    input  wire             dsp_pods_n,
    input  dsp_word_t       dsp_pbus_out,
    input  dsp_word_t       dsp_ab,
    input  wire             dsp_cen_cko,
    output wire dsp_word_t  dsp_pbus_in,
    output wire             dsp_rst,
    output wire             dsp_irq,
    // audio and sample ROM
    output wire sample_t    left,
    output wire sample_t    right,
    output wire             sample,
    output wire qsnd_addr_t qsnd_addr
);

    wire             mbox_wr, bank_wr, dsp_rdy_n;
    wire mbox_idx_t  mbox_idx;
    wire z80_byte_t  wr_data;
    wire bank_t      bank;

    sound_addr_decode u_decode (
        .clk48     (clk48),
        .rst       (rst),
        .z80_addr  (z80_addr),
        .z80_dout  (z80_dout),
        .mreq_n    (mreq_n),
        .rd_n      (rd_n),
        .wr_n      (wr_n),
        .rom_data  (rom_data),
        .ram_dout  (ram_dout),
        .bank      (bank),
        .dsp_rdy_n (dsp_rdy_n),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .mbox_wr   (mbox_wr),
        .mbox_idx  (mbox_idx),
        .bank_wr   (bank_wr),
        .wr_data   (wr_data),
        .z80_din   (z80_din)
    );

    sound_mailbox u_mailbox (
        .clk48       (clk48),
        .rst         (rst),
        .mbox_wr     (mbox_wr),
        .mbox_idx    (mbox_idx),
        .bank_wr     (bank_wr),
        .wr_data     (wr_data),
        .dsp_pids_n  (dsp_pids_n),
        .dsp_iack    (dsp_iack),
        .bank        (bank),
        .dsp_rst     (dsp_rst),
        .dsp_irq     (dsp_irq),
        .dsp_rdy_n   (dsp_rdy_n),
        .dsp_pbus_in (dsp_pbus_in)
    );

    sound_sample_latch u_samples (
        .clk48        (clk48),
        .rst          (rst),
        .dsp_sadd     (dsp_sadd),
        .dsp_psel     (dsp_psel),
        .dsp_serout   (dsp_serout),
        .dsp_pods_n   (dsp_pods_n),
        .dsp_pbus_out (dsp_pbus_out),
        .dsp_ab       (dsp_ab),
        .dsp_cen_cko  (dsp_cen_cko),
        .left         (left),
        .right        (right),
        .sample       (sample),
        .qsnd_addr    (qsnd_addr)
    );

    z80_tick_irq #(
        .irq_period (irq_period)
    ) u_tick (
        .clk48  (clk48),
        .rst    (rst),
        .cen8   (cen8),
        .m1_n   (m1_n),
        .iorq_n (iorq_n),
        .int_n  (int_n)
    );

endmodule

`default_nettype wire

//--- bench/qsound_glue_assertions.sv
//########################################
// protocol checks on the glue top
// bound into every qsound_glue instance
//########################################
`default_nettype none

module qsound_glue_assertions
    import dsp_link_pkg::*;
(
    input wire            clk48,
    input wire            rst,
    input wire            rom_cs,
    input wire            ram_cs,
    input wire            sample,
    input wire            dsp_irq,
    input wire            mbox_wr,
    input wire dsp_word_t dsp_pbus_in
);

    int fail_count = 0;     // failed assertions so far

    // program ROM and work RAM windows never overlap
    cs_exclusive: assert property (@(posedge clk48) disable iff (rst) !(rom_cs && ram_cs))
        else begin
            $error("rom_cs and ram_cs are both set");
            fail_count++;
        end

    sample_single: assert property (@(posedge clk48) disable iff (rst) sample |=> !sample)
        else begin
            $error("sample held high for two cycles");
            fail_count++;
        end

    // DSP side word only moves for a new command or a pending read
    pbus_steady: assert property (@(posedge clk48) disable iff (rst)
        (!dsp_irq && !mbox_wr) |=> $stable(dsp_pbus_in))
        else begin
            $error("dsp_pbus_in changed with no command pending");
            fail_count++;
        end

endmodule

bind qsound_glue qsound_glue_assertions u_assertions (
    .clk48       (clk48),
    .rst         (rst),
    .rom_cs      (rom_cs),
    .ram_cs      (ram_cs),
    .sample      (sample),
    .dsp_irq     (dsp_irq),
    .mbox_wr     (mbox_wr),
    .dsp_pbus_in (dsp_pbus_in)
);

`default_nettype wire

//--- bench/qsound_glue_tb.sv
//########################################
// testbench for the sound board glue
// walks a table of Z80 and DSP steps and compares
// the responses with a reference model
//########################################
`default_nettype none

`include "qsound_params.svh"

module qsound_glue_tb
    import z80_bus_pkg::*, dsp_link_pkg::*;
();

    localparam int IRQ_TB    = 50;
    localparam int N_STEPS   = 36;
    localparam int WD_CYCLES = N_STEPS * 8 + 3 * IRQ_TB + 100;

    localparam int OP_RST  = 0;     // reset values
    localparam int OP_ROM  = 1;
    localparam int OP_RAM  = 2;
    localparam int OP_NONE = 3;     // unmapped read
    localparam int OP_STAT = 4;
    localparam int OP_WR   = 5;
    localparam int OP_PIDS = 6;     // one DSP parallel read
    localparam int OP_IACK = 7;
    localparam int OP_SER  = 8;     // one serial word
    localparam int OP_PSEL = 9;
    localparam int OP_PODS = 10;
    localparam int OP_AB   = 11;
    localparam int OP_IRQ  = 12;

    typedef struct {
        int          op;
        z80_addr_t   addr;
        logic [15:0] data;  // write byte, DSP word or level
        rom_addr_t   exp;   // rom_addr expected on ROM reads
    } step_t;

    step_t steps [N_STEPS] = '{
        '{OP_RST,  16'h0000, 16'h0000, 19'h00000},
        '{OP_ROM,  16'h0000, 16'h0000, 19'h00000},
        '{OP_ROM,  16'h7fff, 16'h0000, 19'h07fff},
        '{OP_ROM,  16'hbfff, 16'h0000, 19'h0bfff},
        '{OP_RAM,  16'hc000, 16'h0000, 19'h00000},
        '{OP_RAM,  16'hffff, 16'h0000, 19'h00000},
        '{OP_NONE, 16'he123, 16'h0000, 19'h00000},
        '{OP_STAT, 16'hd007, 16'h0000, 19'h00000},
        '{OP_WR,   16'hd003, 16'h0085, 19'h00000},
        '{OP_ROM,  16'h8000, 16'h0000, 19'h1c000},
        '{OP_ROM,  16'ha345, 16'h0000, 19'h1e345},
        '{OP_WR,   16'hd000, 16'h0012, 19'h00000},
        '{OP_WR,   16'hd001, 16'h0034, 19'h00000},
        '{OP_WR,   16'hd002, 16'h005a, 19'h00000},
        '{OP_STAT, 16'hd007, 16'h0000, 19'h00000},
        '{OP_PIDS, 16'h0000, 16'h0000, 19'h00000},
        '{OP_PIDS, 16'h0000, 16'h0000, 19'h00000},
        '{OP_STAT, 16'hd00f, 16'h0000, 19'h00000},
        '{OP_WR,   16'hd00b, 16'h000a, 19'h00000},
        '{OP_ROM,  16'hbfff, 16'h0000, 19'h33fff},
        '{OP_IACK, 16'h0000, 16'h0001, 19'h00000},
        '{OP_STAT, 16'hd007, 16'h0000, 19'h00000},
        '{OP_IACK, 16'h0000, 16'h0000, 19'h00000},
        '{OP_WR,   16'hc123, 16'h0099, 19'h00000},
        '{OP_WR,   16'hd003, 16'h008f, 19'h00000},
        '{OP_ROM,  16'hbfff, 16'h0000, 19'h47fff},
        '{OP_SER,  16'h0000, 16'h0000, 19'h00000},
        '{OP_PSEL, 16'h0000, 16'h0001, 19'h00000},
        '{OP_SER,  16'h0000, 16'h0000, 19'h00000},
        '{OP_PSEL, 16'h0000, 16'h0000, 19'h00000},
        '{OP_SER,  16'h0000, 16'h0000, 19'h00000},
        '{OP_PSEL, 16'h0000, 16'h0001, 19'h00000},
        '{OP_PODS, 16'h0000, 16'hbeef, 19'h00000},
        '{OP_AB,   16'h0000, 16'h8035, 19'h00000},
        '{OP_AB,   16'h0000, 16'h0042, 19'h00000},
        '{OP_IRQ,  16'h0000, 16'h0000, 19'h00000}
    };

    logic       clk48 = 1'b0;
    logic       rst, cen8, mreq_n, rd_n, wr_n, m1_n, iorq_n, int_n;
    z80_addr_t  z80_addr;
    z80_byte_t  z80_dout, rom_data, ram_dout, z80_din;
    rom_addr_t  rom_addr;
    logic       rom_cs, ram_cs;
    logic       dsp_pids_n, dsp_iack, dsp_sadd, dsp_psel, dsp_pods_n, dsp_cen_cko;
    dsp_word_t  dsp_serout, dsp_pbus_out, dsp_ab, dsp_pbus_in;
    logic       dsp_rst, dsp_irq, sample;
    sample_t    left, right;
    qsnd_addr_t qsnd_addr;

    // reference model state
    bank_t      m_bank;
    logic       m_rst, m_irq, m_iack, m_psel;
    logic [1:0] m_datasel;
    mbox_word_t m_cmd;
    sample_t    m_reg_l, m_reg_r, m_left, m_right;
    qsnd_addr_t m_qaddr;

    int n_checks, n_errors, n_assert, cur_step, seed_val;

    qsound_glue #(.irq_period(IRQ_TB)) dut (.*);

    always #4 clk48 = ~clk48;

    task automatic tick();
        @(posedge clk48);
        #1;     // drive and sample just after the edge
    endtask

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %s: got %h, expected %h (step %0d)", name, got, exp, cur_step);
        end
    endtask

    task automatic check_byte(input string name, input z80_byte_t got, input z80_byte_t exp);
        report(name, 32'(got), 32'(exp));
    endtask

    task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        report(name, 32'(got), 32'(exp));
    endtask

    task automatic check_word(input string name, input dsp_word_t got, input dsp_word_t exp);
        report(name, 32'(got), 32'(exp));
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        report(name, 32'(unsigned'(got)), 32'(unsigned'(exp)));
    endtask

    task automatic check_qaddr(input string name, input qsnd_addr_t got, input qsnd_addr_t exp);
        report(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        report(name, 32'(got), 32'(exp));
    endtask

    task automatic drive_idle();
        cen8         = 1'b0;
        z80_addr     = '0;
        z80_dout     = '0;
        mreq_n       = 1'b1;
        rd_n         = 1'b1;
        wr_n         = 1'b1;
        m1_n         = 1'b1;
        iorq_n       = 1'b1;
        rom_data     = '0;
        ram_dout     = '0;
        dsp_pids_n   = 1'b1;
        dsp_iack     = 1'b0;
        dsp_sadd     = 1'b0;
        dsp_psel     = 1'b0;
        dsp_serout   = '0;
        dsp_pods_n   = 1'b1;
        dsp_pbus_out = '0;
        dsp_ab       = '0;
        dsp_cen_cko  = 1'b0;
    endtask

    task automatic model_reset();
        m_bank    = '0;
        m_rst     = 1'b1;
        m_irq     = 1'b0;
        m_iack    = 1'b0;
        m_psel    = 1'b0;
        m_datasel = 2'b00;
        m_cmd     = '0;
        m_reg_l   = '0;
        m_reg_r   = '0;
        m_left    = '0;
        m_right   = '0;
        m_qaddr   = '0;
    endtask

    // Z80 write into the 0xDxxx register page
    task automatic model_write(input z80_addr_t a, input z80_byte_t d);
        if (a[15:12] == 4'hd) begin
            case (a[2:0])
                `MBOX_OFS_DHI: m_cmd[15:8] = d;
                `MBOX_OFS_DLO: m_cmd[7:0] = d;
                `MBOX_OFS_ADDR: begin
                    m_cmd[23:16] = d;
                    m_irq        = 1'b1;
                    m_datasel    = 2'b11;
                end
                `BANK_OFS: begin
                    m_bank = d[3:0];
                    m_rst  = ~d[7];
                end
                default: ;
            endcase
        end
    endtask

    function automatic dsp_word_t ref_pbus_in();
        return m_datasel[1] ? {8'h00, m_cmd[23:16]} : m_cmd[15:0];
    endfunction

    function automatic z80_byte_t ref_status();
        return {~(m_irq | m_iack), 3'b111, m_bank};
    endfunction

    task automatic z80_access(input z80_addr_t a, input z80_byte_t d, input logic wr);
        z80_addr = a;
        z80_dout = d;
        mreq_n   = 1'b0;
        rd_n     = wr;
        wr_n     = !wr;
        tick();
    endtask

    task automatic bus_release();
        mreq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        tick();
    endtask

    task automatic irq_ack();
        m1_n   = 1'b0;
        iorq_n = 1'b0;
        tick();
        m1_n   = 1'b1;
        iorq_n = 1'b1;
    endtask

    task automatic mailbox_checks();
        check_bit("dsp_irq", dsp_irq, m_irq);
        check_bit("dsp_rst", dsp_rst, m_rst);
        check_word("dsp_pbus_in", dsp_pbus_in, ref_pbus_in());
    endtask

    task automatic audio_checks();
        check_sample("left", left, m_left);
        check_sample("right", right, m_right);
    endtask

    task automatic run_step(input step_t s);
        dsp_word_t ser;
        logic      rising;
        case (s.op)
            OP_RST: begin
                check_bit("rom_cs", rom_cs, 1'b0);
                check_bit("ram_cs", ram_cs, 1'b0);
                check_bit("sample", sample, 1'b0);
                check_bit("int_n", int_n, 1'b1);
                check_rom_addr("rom_addr", rom_addr, '0);
                check_byte("z80_din", z80_din, 8'hff);
                check_qaddr("qsnd_addr", qsnd_addr, m_qaddr);
                mailbox_checks();
                audio_checks();
            end
            OP_ROM, OP_RAM, OP_NONE, OP_STAT: begin
                rom_data = z80_byte_t'($urandom);
                ram_dout = z80_byte_t'($urandom);
                z80_access(s.addr, 8'h00, 1'b0);
                check_bit("rom_cs", rom_cs, s.op == OP_ROM);
                check_bit("ram_cs", ram_cs, s.op == OP_RAM);
                if (s.op == OP_ROM) begin
                    check_rom_addr("rom_addr", rom_addr, s.exp);
                    check_byte("z80_din", z80_din, rom_data);
                end else if (s.op == OP_RAM)
                    check_byte("z80_din", z80_din, ram_dout);
                else if (s.op == OP_STAT)
                    check_byte("z80_din", z80_din, ref_status());
                else
                    check_byte("z80_din", z80_din, 8'hff);
                bus_release();
            end
            OP_WR: begin
                z80_access(s.addr, s.data[7:0], 1'b1);
                bus_release();      // registers land on this edge
                model_write(s.addr, s.data[7:0]);
                mailbox_checks();
            end
            OP_PIDS: begin
                dsp_pids_n = 1'b0;
                tick();
                dsp_pids_n = 1'b1;
                tick();
                m_irq     = 1'b0;
                m_datasel = m_datasel >> 1;
                mailbox_checks();
            end
            OP_IACK: begin
                dsp_iack = s.data[0];
                m_iack   = s.data[0];
                tick();
            end
            OP_SER: begin
                ser        = dsp_word_t'($urandom);
                dsp_serout = ser;
                dsp_sadd   = 1'b1;
                tick();
                dsp_sadd = 1'b0;
                tick();
                if (m_psel)
                    m_reg_r = sample_t'(ser << `QSND_GAIN);
                else
                    m_reg_l = sample_t'(ser << `QSND_GAIN);
                check_bit("sample", sample, 1'b0);
                audio_checks();
            end
            OP_PSEL: begin
                rising   = s.data[0] && !m_psel;
                dsp_psel = s.data[0];
                m_psel   = s.data[0];
                tick();
                if (rising) begin
                    m_left  = m_reg_l;
                    m_right = m_reg_r;
                end
                check_bit("sample", sample, rising);
                audio_checks();
                tick();
                check_bit("sample", sample, 1'b0);  // single pulse
            end
            OP_PODS: begin
                dsp_pbus_out = s.data;
                dsp_pods_n   = 1'b0;
                tick();
                dsp_pods_n = 1'b1;
                tick();
                m_qaddr[15:0] = s.data;
                check_qaddr("qsnd_addr", qsnd_addr, m_qaddr);
            end
            OP_AB: begin
                dsp_ab      = s.data;
                dsp_cen_cko = 1'b1;
                tick();
                if (s.data[15])
                    m_qaddr[22:16] = s.data[6:0];
                check_qaddr("qsnd_addr", qsnd_addr, m_qaddr);
                dsp_ab      = '0;
                dsp_cen_cko = 1'b0;
            end
            OP_IRQ: begin
                cen8 = 1'b1;
                repeat (IRQ_TB - 1) tick();
                check_bit("int_n", int_n, 1'b1);
                tick();
                check_bit("int_n", int_n, 1'b0);
                repeat (2) tick();
                irq_ack();
                check_bit("int_n", int_n, 1'b1);
                // counter kept running through the acknowledge
                repeat (IRQ_TB - 4) tick();
                check_bit("int_n", int_n, 1'b1);
                tick();
                check_bit("int_n", int_n, 1'b0);
                irq_ack();
                check_bit("int_n", int_n, 1'b1);
                cen8 = 1'b0;
            end
            default: begin
                n_errors++;
                $display("unknown operation code %0d in step %0d", s.op, cur_step);
            end
        endcase
    endtask

    initial begin
        seed_val = $urandom(32'hc5be);
        n_checks = 0;
        n_errors = 0;
        n_assert = 0;
        cur_step = 0;
        model_reset();
        drive_idle();
        rst = 1'b1;
        repeat (8) @(posedge clk48);
        #1;
        rst = 1'b0;
        for (int i = 0; i < N_STEPS; i++) begin
            cur_step = i;
            run_step(steps[i]);
        end
        n_assert = dut.u_assertions.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 n_checks, n_errors, n_assert);
        if (n_errors == 0 && n_assert == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk48);
        $display("timeout: the step table did not complete within %0d cycles", WD_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
logic/z80_bus_pkg.sv
logic/dsp_link_pkg.sv
logic/sound_addr_decode.sv
logic/sound_mailbox.sv
logic/sound_sample_latch.sv
logic/z80_tick_irq.sv
logic/qsound_glue.sv
bench/qsound_glue_assertions.sv
bench/qsound_glue_tb.sv

//--- Bender.yml
package:
  name: qsound_glue

sources:
  - target: rtl
    include_dirs:
      - logic
    files:
      - logic/z80_bus_pkg.sv
      - logic/dsp_link_pkg.sv
      - logic/sound_addr_decode.sv
      - logic/sound_mailbox.sv
      - logic/sound_sample_latch.sv
      - logic/z80_tick_irq.sv
      - logic/qsound_glue.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/qsound_glue_assertions.sv
      - bench/qsound_glue_tb.sv
